/* dv/cluster_tb.sv */
`timescale 1ns/1ps

module cluster_tb;
    import dcr_pkg::*;
    import cluster_cfg_pkg::*;

    localparam int    NUM_SOCKETS     = 4;
    localparam int    CYCLES_PER_LINE = 50;
    localparam string TESTS_FILE      = "dv/cluster_tests.txt";

    logic                        clk;
    logic                        reset;
    logic                        dcr_wr_valid;
    dcr_addr_t                   dcr_wr_addr;
    dcr_data_t                   dcr_wr_data;
    logic [NUM_SOCKETS-1:0]      bar_valid;
    bar_id_t   [NUM_SOCKETS-1:0] bar_id;
    bar_size_t [NUM_SOCKETS-1:0] bar_size_m1;
    dcr_data_t [NUM_SOCKETS-1:0] startup_addr;
    logic [NUM_SOCKETS-1:0]      bar_release;
    logic                        busy;

    // Sockets with a barrier in flight
    logic [NUM_SOCKETS-1:0]      pending;
    // Releases not yet claimed by an expect_release line
    logic [NUM_SOCKETS-1:0]      seen;
    int                          cycle_cnt = 0;
    int                          cycle_limit = 0;

    cluster #(
        .NUM_SOCKETS (NUM_SOCKETS)
    ) cluster_inst (
        .clk          (clk),
        .reset        (reset),
        .dcr_wr_valid (dcr_wr_valid),
        .dcr_wr_addr  (dcr_wr_addr),
        .dcr_wr_data  (dcr_wr_data),
        .bar_valid    (bar_valid),
        .bar_id       (bar_id),
        .bar_size_m1  (bar_size_m1),
        .startup_addr (startup_addr),
        .bar_release  (bar_release),
        .busy         (busy)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_limit > 0 && cycle_cnt > cycle_limit) begin
            $display("simulation timed out after %0d cycles", cycle_cnt);
            abort_run();
        end
    end

    task automatic abort_run();
        $display("test failed");
        $fatal(1);
    endtask

    task automatic check_addr(input string name, input dcr_data_t got, input dcr_data_t exp);
        if (got !== exp) begin
            $display("FAILED %s: got %h, expected %h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_mask(input string name, input logic [NUM_SOCKETS-1:0] got,
                              input logic [NUM_SOCKETS-1:0] exp);
        if (got !== exp) begin
            $display("FAILED %s: got %h, expected %h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("FAILED %s: got %h, expected %h", name, got, exp);
            abort_run();
        end
    endtask

    // One clock cycle, with releases and busy sampled mid-cycle
    task automatic step();
        @(negedge clk);
        check_bit("busy", busy, pending != '0);
        if ((bar_release & ~pending) != '0) begin
            $display("unexpected barrier release from socket mask %h", bar_release & ~pending);
            abort_run();
        end
        seen    = seen | bar_release;
        pending = pending & ~bar_release;
        @(posedge clk);
        #1;
        pending      = pending | bar_valid;
        bar_valid    = '0;
        dcr_wr_valid = 1'b0;
    endtask

    task automatic wait_release(input logic [NUM_SOCKETS-1:0] exp);
        while (seen != exp) begin
            if ((seen & ~exp) != '0) begin
                $display("unexpected barrier release from socket mask %h", seen & ~exp);
                abort_run();
            end
            step();
        end
        seen = '0;
    endtask

    function automatic bit is_command(input string line);
        string word;
        return ($sscanf(line, "%s", word) == 1) && (word[0] != "#");
    endfunction

    task automatic run_command(input string cmd, input int a0, input int a1, input int a2);
        case (cmd)
            "write": begin
                dcr_wr_valid = 1'b1;
                dcr_wr_addr  = dcr_addr_t'(a0);
                dcr_wr_data  = dcr_data_t'(a1);
            end
            "bar": begin
                bar_valid[a0]   = 1'b1;
                bar_id[a0]      = bar_id_t'(a1);
                bar_size_m1[a0] = bar_size_t'(a2 - 1);
            end
            "idle": repeat (a0) step();
            "expect_addr": begin
                check_addr($sformatf("startup_addr[%0d]", a0), startup_addr[a0],
                           dcr_data_t'(a1));
            end
            "expect_release": wait_release(a0[NUM_SOCKETS-1:0]);
            default: begin
                $display("unknown command %s in %s", cmd, TESTS_FILE);
                abort_run();
            end
        endcase
    endtask

    initial begin
        int    fd;
        int    n_lines;
        int    a0;
        int    a1;
        int    a2;
        string line;
        string cmd;

        reset        = 1'b1;
        dcr_wr_valid = 1'b0;
        dcr_wr_addr  = '0;
        dcr_wr_data  = '0;
        bar_valid    = '0;
        bar_id       = '0;
        bar_size_m1  = '0;
        pending      = '0;
        seen         = '0;

        fd = $fopen(TESTS_FILE, "r");
        if (fd == 0) begin
            $display("cannot open %s", TESTS_FILE);
            abort_run();
        end
        n_lines = 0;
        while ($fgets(line, fd) > 0) begin
            if (is_command(line)) begin
                n_lines++;
            end
        end
        $fclose(fd);
        cycle_limit = n_lines * CYCLES_PER_LINE;

        repeat (2) @(posedge clk);
        #1;
        reset = 1'b0;

        for (int s = 0; s < NUM_SOCKETS; s++) begin
            check_addr($sformatf("startup_addr[%0d]", s), startup_addr[s], '0);
        end
        check_bit("busy", busy, 1'b0);
        check_mask("bar_release", bar_release, '0);

        fd = $fopen(TESTS_FILE, "r");
        while ($fgets(line, fd) > 0) begin
            if (is_command(line)) begin
                a0 = 0;
                a1 = 0;
                a2 = 0;
                void'($sscanf(line, "%s %h %h %h", cmd, a0, a1, a2));
                run_command(cmd, a0, a1, a2);
            end
        end
        $fclose(fd);

        $display("test passed");
        $finish;
    end

endmodule

/* dv/cluster_tests.txt */
# write addr data | bar socket id participants | idle cycles
# expect_addr socket data | expect_release socket_mask      (all fields hex)
write 001 cafe0001
idle 1
expect_addr 0 00000000
idle 1
expect_addr 0 cafe0001
expect_addr 3 cafe0001
write 009 deadbeef
idle 1
write 002 12345678
idle 3
expect_addr 1 cafe0001
expect_addr 2 cafe0001
bar 0 3 3
idle 4
bar 1 3 3
idle 5
expect_release 0
bar 2 3 3
expect_release 7
bar 0 2 2
bar 1 7 2
idle 4
bar 3 2 2
expect_release 9
bar 2 7 2
expect_release 6
bar 0 5 4
bar 1 5 4
bar 2 5 4
bar 3 5 4
expect_release f
idle 3
expect_release 0

/* flist.f */
verilog/cluster_cfg_pkg.sv
verilog/dcr_pkg.sv
verilog/gbar_bus_if.sv
verilog/dcr_filter.sv
verilog/gbar_arb.sv
verilog/gbar_unit.sv
verilog/socket_ctrl.sv
verilog/cluster.sv
dv/cluster_tb.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module cluster_tb -f flist.f -o cluster_sim

./obj_dir/cluster_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "^test passed$" sim.log; then
    exit 0
fi
exit 1

/* verilog/cluster.sv */
`timescale 1ns/1ps

module cluster #(
    parameter int NUM_SOCKETS = 4
) (
    input  logic                                         clk,
    input  logic                                         reset,
    input  logic                                         dcr_wr_valid,
    input  dcr_pkg::dcr_addr_t                           dcr_wr_addr,
    input  dcr_pkg::dcr_data_t                           dcr_wr_data,
    input  logic [NUM_SOCKETS-1:0]                       bar_valid,
    input  cluster_cfg_pkg::bar_id_t   [NUM_SOCKETS-1:0] bar_id,
    input  cluster_cfg_pkg::bar_size_t [NUM_SOCKETS-1:0] bar_size_m1,
    output dcr_pkg::dcr_data_t         [NUM_SOCKETS-1:0] startup_addr,
    output logic [NUM_SOCKETS-1:0]                       bar_release,
    output logic                                         busy
);
    import dcr_pkg::*;

    logic                   sock_dcr_valid;
    dcr_addr_t              sock_dcr_addr;
    dcr_data_t              sock_dcr_data;
    logic [NUM_SOCKETS-1:0] sock_busy;

    gbar_bus_if sock_bus_if [NUM_SOCKETS] ();
    gbar_bus_if unit_bus_if ();

    dcr_filter dcr_filter_inst (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (dcr_wr_valid),
        .in_addr   (dcr_wr_addr),
        .in_data   (dcr_wr_data),
        .out_valid (sock_dcr_valid),
        .out_addr  (sock_dcr_addr),
        .out_data  (sock_dcr_data)
    );

    for (genvar i = 0; i < NUM_SOCKETS; i++) begin : g_socket
        socket_ctrl #(
            .SOCKET_ID (i)
        ) socket_ctrl_inst (
            .clk          (clk),
            .reset        (reset),
            .dcr_valid    (sock_dcr_valid),
            .dcr_addr     (sock_dcr_addr),
            .dcr_data     (sock_dcr_data),
            .bar_valid    (bar_valid[i]),
            .bar_id       (bar_id[i]),
            .bar_size_m1  (bar_size_m1[i]),
            .startup_addr (startup_addr[i]),
            .bar_release  (bar_release[i]),
            .busy         (sock_busy[i]),
            .gbar_bus_if  (sock_bus_if[i])
        );
    end

    gbar_arb #(
        .NUM_INPUTS (NUM_SOCKETS)
    ) gbar_arb_inst (
        .clk        (clk),
        .reset      (reset),
        .bus_in_if  (sock_bus_if),
        .bus_out_if (unit_bus_if)
    );

    gbar_unit gbar_unit_inst (
        .clk         (clk),
        .reset       (reset),
        .gbar_bus_if (unit_bus_if)
    );

    // Busy while any socket waits on a barrier
    assign busy = |sock_busy;

endmodule

/* verilog/cluster_cfg_pkg.sv */
package cluster_cfg_pkg;

    // Socket limits
    localparam int MAX_SOCKETS = 8;
    localparam int SOCKET_IDX_W = $clog2(MAX_SOCKETS);

    // Barrier limits
    localparam int NUM_BARRIERS = 16;
    localparam int BAR_ID_W = $clog2(NUM_BARRIERS);

    // Index of the socket issuing a barrier request
    typedef logic [SOCKET_IDX_W-1:0] socket_idx_t;

    // Barrier id
    typedef logic [BAR_ID_W-1:0] bar_id_t;

    // Participant count minus one, so a full cluster fits in 3 bits
    typedef logic [SOCKET_IDX_W-1:0] bar_size_t;

endpackage

/* verilog/dcr_filter.sv */
`timescale 1ns/1ps

module dcr_filter (
    input  logic               clk,
    input  logic               reset,
    input  logic               in_valid,
    input  dcr_pkg::dcr_addr_t in_addr,
    input  dcr_pkg::dcr_data_t in_data,
    output logic               out_valid,
    output dcr_pkg::dcr_addr_t out_addr,
    output dcr_pkg::dcr_data_t out_data
);
    import dcr_pkg::*;

    logic in_range;

    assign in_range = (in_addr >= DCR_BASE_STATE_BEGIN) && (in_addr < DCR_BASE_STATE_END);

    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= in_valid && in_range;
        end
    end

    // Only accepted writes load the payload
    always_ff @(posedge clk) begin
        if (in_valid && in_range) begin
            out_addr <= in_addr;
            out_data <= in_data;
        end
    end

    a_out_in_range: assert property (@(posedge clk) disable iff (reset)
        out_valid |-> (out_addr >= DCR_BASE_STATE_BEGIN) && (out_addr < DCR_BASE_STATE_END));

endmodule

/* verilog/dcr_pkg.sv */
package dcr_pkg;

    localparam int DCR_ADDR_W = 12;
    localparam int DCR_DATA_W = 32;

    typedef logic [DCR_ADDR_W-1:0] dcr_addr_t;
    typedef logic [DCR_DATA_W-1:0] dcr_data_t;

    // Base state window, end is exclusive
    localparam dcr_addr_t DCR_BASE_STATE_BEGIN = 12'h001;
    localparam dcr_addr_t DCR_BASE_STATE_END   = 12'h008;

    // Registers inside the base window
    localparam dcr_addr_t DCR_BASE_STARTUP_ADDR = 12'h001;

endpackage

/* verilog/gbar_arb.sv */
`timescale 1ns/1ps

module gbar_arb #(
    parameter int NUM_INPUTS = 4
) (
    input  logic       clk,
    input  logic       reset,
    gbar_bus_if.slave  bus_in_if [NUM_INPUTS],
    gbar_bus_if.master bus_out_if
);
    import cluster_cfg_pkg::*;

    localparam int IDX_W = (NUM_INPUTS > 1) ? $clog2(NUM_INPUTS) : 1;

    logic [NUM_INPUTS-1:0] in_valid;
    logic [NUM_INPUTS-1:0] in_ready;
    logic [NUM_INPUTS-1:0] grant;
    bar_id_t               in_id      [NUM_INPUTS];
    bar_size_t             in_size_m1 [NUM_INPUTS];
    socket_idx_t           in_socket  [NUM_INPUTS];
    logic [IDX_W-1:0]      last_idx;
    logic [IDX_W-1:0]      grant_idx;

    for (genvar i = 0; i < NUM_INPUTS; i++) begin : g_in
        assign in_valid[i]   = bus_in_if[i].req_valid;
        assign in_id[i]      = bus_in_if[i].req_id;
        assign in_size_m1[i] = bus_in_if[i].req_size_m1;
        assign in_socket[i]  = bus_in_if[i].req_socket;
        assign in_ready[i]   = grant[i] && bus_out_if.req_ready;

        assign bus_in_if[i].req_ready = in_ready[i];
        assign bus_in_if[i].rsp_valid = bus_out_if.rsp_valid;
        assign bus_in_if[i].rsp_id    = bus_out_if.rsp_id;
    end

    // Scan from farthest to nearest so the first valid after last_idx wins
    always_comb begin
        grant     = '0;
        grant_idx = last_idx;
        for (int k = NUM_INPUTS; k >= 1; k--) begin
            if (in_valid[(int'(last_idx) + k) % NUM_INPUTS]) begin
                grant_idx = IDX_W'((int'(last_idx) + k) % NUM_INPUTS);
            end
        end
        if (|in_valid) begin
            grant[grant_idx] = 1'b1;
        end
    end

    assign bus_out_if.req_valid   = |in_valid;
    assign bus_out_if.req_id      = in_id[grant_idx];
    assign bus_out_if.req_size_m1 = in_size_m1[grant_idx];
    assign bus_out_if.req_socket  = in_socket[grant_idx];

    // Start so that input 0 has first priority
    always_ff @(posedge clk) begin
        if (reset) begin
            last_idx <= IDX_W'(NUM_INPUTS - 1);
        end else if (bus_out_if.req_valid && bus_out_if.req_ready) begin
            last_idx <= grant_idx;
        end
    end

    a_one_ready: assert property (@(posedge clk) disable iff (reset) $onehot0(in_ready));

endmodule

/* verilog/gbar_bus_if.sv */
`timescale 1ns/1ps

interface gbar_bus_if;
    import cluster_cfg_pkg::*;

    // Request side
    logic        req_valid;
    bar_id_t     req_id;
    bar_size_t   req_size_m1;
    socket_idx_t req_socket;
    logic        req_ready;

    // Release broadcast, single-cycle pulse
    logic        rsp_valid;
    bar_id_t     rsp_id;

    modport master (
        output req_valid, req_id, req_size_m1, req_socket,
        input  req_ready, rsp_valid, rsp_id
    );

    modport slave (
        input  req_valid, req_id, req_size_m1, req_socket,
        output req_ready, rsp_valid, rsp_id
    );

endinterface

/* verilog/gbar_unit.sv */
`timescale 1ns/1ps

module gbar_unit (
    input  logic      clk,
    input  logic      reset,
    gbar_bus_if.slave gbar_bus_if
);
    import cluster_cfg_pkg::*;

    localparam int CNT_W = $clog2(MAX_SOCKETS + 1);

    logic [MAX_SOCKETS-1:0] arrive_mask [NUM_BARRIERS];
    logic [MAX_SOCKETS-1:0] sock_bit;
    logic [MAX_SOCKETS-1:0] next_mask;
    logic [CNT_W-1:0]       arrive_cnt;
    logic                   req_fire;
    logic                   complete;
    logic                   rsp_valid_q;
    bar_id_t                rsp_id_q;

    // Never stalls, the arbiter grant is the only back-pressure
    assign gbar_bus_if.req_ready = 1'b1;

    assign req_fire   = gbar_bus_if.req_valid && gbar_bus_if.req_ready;
    assign sock_bit   = MAX_SOCKETS'(1) << gbar_bus_if.req_socket;
    assign next_mask  = arrive_mask[gbar_bus_if.req_id] | sock_bit;
    assign arrive_cnt = CNT_W'($countones(next_mask));
    assign complete   = arrive_cnt == (CNT_W'(gbar_bus_if.req_size_m1) + CNT_W'(1));

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < NUM_BARRIERS; i++) begin
                arrive_mask[i] <= '0;
            end
            rsp_valid_q <= 1'b0;
        end else begin
            rsp_valid_q <= req_fire && complete;
            if (req_fire) begin
                // Last arrival frees the id for reuse
                arrive_mask[gbar_bus_if.req_id] <= complete ? '0 : next_mask;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (req_fire && complete) begin
            rsp_id_q <= gbar_bus_if.req_id;
        end
    end

    assign gbar_bus_if.rsp_valid = rsp_valid_q;
    assign gbar_bus_if.rsp_id    = rsp_id_q;

    // A socket must wait for release before it arrives at the same barrier again
    a_no_double_arrival: assert property (@(posedge clk) disable iff (reset)
        req_fire |-> !arrive_mask[gbar_bus_if.req_id][gbar_bus_if.req_socket]);

endmodule

/* verilog/socket_ctrl.sv */
`timescale 1ns/1ps

module socket_ctrl #(
    parameter int SOCKET_ID = 0
) (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       dcr_valid,
    input  dcr_pkg::dcr_addr_t         dcr_addr,
    input  dcr_pkg::dcr_data_t         dcr_data,
    input  logic                       bar_valid,
    input  cluster_cfg_pkg::bar_id_t   bar_id,
    input  cluster_cfg_pkg::bar_size_t bar_size_m1,
    output dcr_pkg::dcr_data_t         startup_addr,
    output logic                       bar_release,
    output logic                       busy,
    gbar_bus_if.master                 gbar_bus_if
);
    import dcr_pkg::*;
    import cluster_cfg_pkg::*;

    typedef enum logic [1:0] {
        IDLE,
        REQUEST,
        WAIT
    } state_t;

    state_t    state;
    bar_id_t   req_id_q;
    bar_size_t req_size_q;
    logic      rsp_match;

    always_ff @(posedge clk) begin
        if (reset) begin
            startup_addr <= '0;
        end else if (dcr_valid && (dcr_addr == DCR_BASE_STARTUP_ADDR)) begin
            startup_addr <= dcr_data;
        end
    end

    assign rsp_match = gbar_bus_if.rsp_valid && (gbar_bus_if.rsp_id == req_id_q);

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE:    if (bar_valid) state <= REQUEST;
                REQUEST: if (gbar_bus_if.req_ready) state <= WAIT;
                WAIT:    if (rsp_match) state <= IDLE;
                default: state <= IDLE;
            endcase
        end
    end

    // Barrier fields held steady through REQUEST and WAIT
    always_ff @(posedge clk) begin
        if (state == IDLE && bar_valid) begin
            req_id_q   <= bar_id;
            req_size_q <= bar_size_m1;
        end
    end

    assign gbar_bus_if.req_valid   = (state == REQUEST);
    assign gbar_bus_if.req_id      = req_id_q;
    assign gbar_bus_if.req_size_m1 = req_size_q;
    assign gbar_bus_if.req_socket  = socket_idx_t'(SOCKET_ID);

    assign bar_release = (state == WAIT) && rsp_match;
    assign busy        = (state != IDLE);

endmodule
